/* conv_pool.f */
+incdir+verification
rtl/conv_pool_pkg.sv
rtl/kernel_store.sv
rtl/conv_lane.sv
rtl/pool_activate.sv
rtl/conv_pool_top.sv
verification/tb_conv_pool.sv

/* rtl/conv_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_lane (
  input  wire                           aclk,
  input  wire                           reset,
  input  wire                           pix_valid,
  input  wire conv_pool_pkg::stream_beat_t pix_beat,
  output logic                          pix_ready,
  input  wire conv_pool_pkg::kernel_t   kernel,
  input  wire                           kernel_valid,
  input  wire                           take,
  output logic                          sum_valid,
  output conv_pool_pkg::lane_sum_t      sum,
  output logic                          busy
);
  import conv_pool_pkg::*;

  logic [TAP_IDX_WIDTH-1:0]       tap;
  acc_t                           acc;
  logic signed [2*WORD_WIDTH-1:0] product;
  logic                           pix_xfer;

  // stall the pixel stream until the combiner takes the sum
  assign pix_ready = kernel_valid && !sum_valid;
  assign pix_xfer  = pix_valid && pix_ready;

  assign product = pix_beat.data * kernel[tap];  // signed 8x8

  assign busy = (tap != '0) || sum_valid;

  // the accumulator doubles as the held result
  assign sum.sum = acc;

  always_ff @(posedge aclk) begin
    if (reset) begin
      tap       <= '0;
      acc       <= '0;
      sum_valid <= 1'b0;
    end else if (take) begin
      tap       <= '0;
      acc       <= '0;
      sum_valid <= 1'b0;
    end else if (pix_xfer) begin
      acc       <= acc + acc_t'(product);  // sign extend
      tap       <= tap + 1'b1;
      sum_valid <= pix_beat.last;
    end
  end

  // window length matches the kernel
  a_last_on_final_tap : assert property (
    @(posedge aclk) disable iff (reset)
    pix_xfer |-> (pix_beat.last == (tap == TAP_IDX_WIDTH'(TAPS - 1)))
  );

  a_sum_held : assert property (
    @(posedge aclk) disable iff (reset)
    (sum_valid && !take) |=> (sum_valid && $stable(sum))
  );

endmodule

`default_nettype wire

/* rtl/conv_pool_pkg.sv */
`default_nettype none

package conv_pool_pkg;

  // datapath widths
  localparam int WORD_WIDTH    = 8;   // pixel, weight and output value
  localparam int ACC_WIDTH     = 20;  // 9 products of 16 bits plus growth

  // kernel geometry, 3x3
  localparam int TAPS          = 9;
  localparam int TAP_IDX_WIDTH = 4;

  // activation and requantization
  localparam int LRELU_SHIFT   = 3;   // negative slope of 1/8
  localparam int OUT_SHIFT     = 4;

  typedef logic signed [WORD_WIDTH-1:0] word_t;
  typedef logic signed [ACC_WIDTH-1:0]  acc_t;

  // one beat on a weight or pixel stream
  typedef struct packed {
    word_t data;
    logic  last;
  } stream_beat_t;

  // tap 0 sits in the low word
  typedef word_t [TAPS-1:0] kernel_t;

  // dot product handed from a lane to the combiner
  typedef struct packed {
    acc_t sum;
  } lane_sum_t;

endpackage

`default_nettype wire

/* rtl/conv_pool_top.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_pool_top (
  input  wire                              aclk,
  input  wire                              reset,

  input  wire                              weight_valid,
  input  wire conv_pool_pkg::stream_beat_t weight_beat,
  output wire                              weight_ready,

  input  wire                              pix1_valid,
  input  wire conv_pool_pkg::stream_beat_t pix1_beat,
  output wire                              pix1_ready,

  input  wire                              pix2_valid,
  input  wire conv_pool_pkg::stream_beat_t pix2_beat,
  output wire                              pix2_ready,

  output wire                              out_valid,
  output wire conv_pool_pkg::word_t        out_data,
  input  wire                              out_ready
);
  import conv_pool_pkg::*;

  kernel_t   kernel;
  logic      kernel_valid;
  logic      lane1_busy;
  logic      lane2_busy;
  logic      sum1_valid;
  lane_sum_t sum1;
  logic      sum2_valid;
  lane_sum_t sum2;
  logic      take;  // shared by both lanes

  kernel_store kernel_store (
    .aclk         (aclk),
    .reset        (reset),
    .weight_valid (weight_valid),
    .weight_beat  (weight_beat),
    .weight_ready (weight_ready),
    .lane1_busy   (lane1_busy),
    .lane2_busy   (lane2_busy),
    .kernel       (kernel),
    .kernel_valid (kernel_valid)
  );

  conv_lane lane1 (
    .aclk         (aclk),
    .reset        (reset),
    .pix_valid    (pix1_valid),
    .pix_beat     (pix1_beat),
    .pix_ready    (pix1_ready),
    .kernel       (kernel),
    .kernel_valid (kernel_valid),
    .take         (take),
    .sum_valid    (sum1_valid),
    .sum          (sum1),
    .busy         (lane1_busy)
  );

  conv_lane lane2 (
    .aclk         (aclk),
    .reset        (reset),
    .pix_valid    (pix2_valid),
    .pix_beat     (pix2_beat),
    .pix_ready    (pix2_ready),
    .kernel       (kernel),
    .kernel_valid (kernel_valid),
    .take         (take),
    .sum_valid    (sum2_valid),
    .sum          (sum2),
    .busy         (lane2_busy)
  );

  pool_activate pool_activate (
    .aclk       (aclk),
    .reset      (reset),
    .sum1_valid (sum1_valid),
    .sum1       (sum1),
    .sum2_valid (sum2_valid),
    .sum2       (sum2),
    .take       (take),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_ready  (out_ready)
  );

endmodule

`default_nettype wire

/* rtl/kernel_store.sv */
`timescale 1ns/1ps
`default_nettype none

module kernel_store (
  input  wire                           aclk,
  input  wire                           reset,
  input  wire                           weight_valid,
  input  wire conv_pool_pkg::stream_beat_t weight_beat,
  output logic                          weight_ready,
  input  wire                           lane1_busy,
  input  wire                           lane2_busy,
  output conv_pool_pkg::kernel_t        kernel,
  output logic                          kernel_valid
);
  import conv_pool_pkg::*;

  logic [TAP_IDX_WIDTH-1:0] wr_idx;
  logic                     weight_xfer;

  // hold off a reload while either lane has a window in flight
  assign weight_ready = !(kernel_valid && (lane1_busy || lane2_busy));
  assign weight_xfer  = weight_valid && weight_ready;

  always_ff @(posedge aclk) begin
    if (reset) begin
      wr_idx       <= '0;
      kernel_valid <= 1'b0;
    end else if (weight_xfer) begin
      // first beat drops valid, last beat raises it again
      kernel_valid <= weight_beat.last;
      if (weight_beat.last) begin
        wr_idx <= '0;
      end else begin
        wr_idx <= wr_idx + 1'b1;
      end
    end
  end

  // tap registers
  always_ff @(posedge aclk) begin
    if (weight_xfer) begin
      kernel[wr_idx] <= weight_beat.data;
    end
  end

  // a load is exactly TAPS beats with last on the final one
  a_last_on_final_tap : assert property (
    @(posedge aclk) disable iff (reset)
    weight_xfer |-> (weight_beat.last == (wr_idx == TAP_IDX_WIDTH'(TAPS - 1)))
  );

endmodule

`default_nettype wire

/* rtl/pool_activate.sv */
`timescale 1ns/1ps
`default_nettype none

module pool_activate (
  input  wire                           aclk,
  input  wire                           reset,
  input  wire                           sum1_valid,
  input  wire conv_pool_pkg::lane_sum_t sum1,
  input  wire                           sum2_valid,
  input  wire conv_pool_pkg::lane_sum_t sum2,
  output logic                          take,
  output logic                          out_valid,
  output conv_pool_pkg::word_t          out_data,
  input  wire                           out_ready
);
  import conv_pool_pkg::*;

  acc_t  pooled;
  acc_t  leaky;
  acc_t  scaled;
  logic  in_range;
  word_t result;

  // join both rows, output slot must be free or freeing now
  assign take = sum1_valid && sum2_valid && (!out_valid || out_ready);

  always_comb begin
    pooled = (sum1.sum > sum2.sum) ? sum1.sum : sum2.sum;  // max of the two rows

    // leaky relu
    if (pooled[ACC_WIDTH-1]) begin
      leaky = pooled >>> LRELU_SHIFT;
    end else begin
      leaky = pooled;
    end

    scaled = leaky >>> OUT_SHIFT;

    // fits when the bits above the output sign are all copies of it
    in_range = (&scaled[ACC_WIDTH-1:WORD_WIDTH-1]) || !(|scaled[ACC_WIDTH-1:WORD_WIDTH-1]);

    if (in_range) begin
      result = scaled[WORD_WIDTH-1:0];
    end else if (scaled[ACC_WIDTH-1]) begin
      result = {1'b1, {(WORD_WIDTH-1){1'b0}}};  // -128
    end else begin
      result = {1'b0, {(WORD_WIDTH-1){1'b1}}};  // 127
    end
  end

  always_ff @(posedge aclk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (take) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      out_data <= result;
    end
  end

  a_out_held : assert property (
    @(posedge aclk) disable iff (reset)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and scan the log for the verdict

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_conv_pool -Mdir "$BUILD_DIR" -f conv_pool.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_conv_pool" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "=== PASS ===" "$LOG"; then
  echo "simulation passed"
  exit 0
else
  echo "pass message not found in $LOG"
  exit 1
fi

/* verification/tb_conv_pool_checks.svh */
`ifndef TB_CONV_POOL_CHECKS_SVH
`define TB_CONV_POOL_CHECKS_SVH

task automatic check_sum(input acc_t got, input acc_t expected, input string what);
  if (got !== expected) begin
    abort_run($sformatf("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, expected));
  end
endtask

task automatic check_out(input word_t got, input word_t expected, input string what);
  if (got !== expected) begin
    abort_run($sformatf("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, expected));
  end
endtask

// port 0 is the weight stream, 1 and 2 the pixel lanes
function automatic logic ready_of(input int port);
  return (port == 0) ? weight_ready : (port == 1) ? pix1_ready : pix2_ready;
endfunction

function automatic string port_name(input int port);
  return (port == 0) ? "weight_ready" : (port == 1) ? "pix1_ready" : "pix2_ready";
endfunction

// returns at the negedge before the accepting edge
task automatic wait_ready(input int port);
  int cycles = 0;
  @(negedge aclk);
  while (!ready_of(port)) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout: %s never went high", port_name(port)));
    end
    @(negedge aclk);
  end
endtask

task automatic wait_out_valid();
  int cycles = 0;
  @(negedge aclk);
  while (!out_valid) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      abort_run("timeout: out_valid never went high");
    end
    @(negedge aclk);
  end
endtask

task automatic wait_outputs(input int n);
  int cycles = 0;
  while (got_q.size() < n) begin
    @(posedge aclk);
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout: only %0d of %0d results came out", got_q.size(), n));
    end
  end
endtask

// rounds toward minus infinity like an arithmetic shift
function automatic int floor_div(input int x, input int d);
  if (x >= 0) begin
    return x / d;
  end
  return -((-x + d - 1) / d);
endfunction

function automatic acc_t dot_product(input window_t pix, input kernel_t k);
  int total = 0;
  for (int i = 0; i < TAPS; i++) begin
    total += int'($signed(pix[i])) * int'($signed(k[i]));
  end
  return acc_t'(total);
endfunction

function automatic acc_t pool_max(input acc_t a, input acc_t b);
  if (b > a) begin
    return b;
  end
  return a;
endfunction

function automatic acc_t leaky_relu(input acc_t v);
  if (v < 0) begin
    return acc_t'(floor_div(v, 1 << LRELU_SHIFT));
  end
  return v;
endfunction

function automatic word_t requantize(input acc_t v);
  int q;
  int hi;
  hi = (1 << (WORD_WIDTH - 1)) - 1;
  q = floor_div(v, 1 << OUT_SHIFT);
  if (q > hi) begin
    q = hi;
  end else if (q < -hi - 1) begin
    q = -hi - 1;
  end
  return word_t'(q);
endfunction

function automatic word_t pooled_out(input window_t w1, input window_t w2, input kernel_t k);
  return requantize(leaky_relu(pool_max(dot_product(w1, k), dot_product(w2, k))));
endfunction

`endif

/* verification/tb_conv_pool.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_conv_pool;
  import conv_pool_pkg::*;

  localparam int          TIMEOUT_CYCLES = 200;
  localparam int          STALL_CYCLES   = 12;
  localparam logic [15:0] LFSR_SEED      = 16'd62346;
  localparam logic [15:0] LFSR_TAPS      = 16'hB400;  // x^16 + x^14 + x^13 + x^11 + 1

  typedef word_t [TAPS-1:0] window_t;  // tap 0 in the low word, like kernel_t

  logic         aclk;
  logic         reset;
  logic         weight_valid;
  stream_beat_t weight_beat;
  logic         weight_ready;
  logic         pix1_valid;
  stream_beat_t pix1_beat;
  logic         pix1_ready;
  logic         pix2_valid;
  stream_beat_t pix2_beat;
  logic         pix2_ready;
  logic         out_valid;
  word_t        out_data;
  logic         out_ready;

  logic [15:0]  lfsr_state;
  kernel_t      kernel_now;  // what the DUT should hold
  word_t        got_q [$];

  conv_pool_top dut (
    .aclk         (aclk),
    .reset        (reset),
    .weight_valid (weight_valid),
    .weight_beat  (weight_beat),
    .weight_ready (weight_ready),
    .pix1_valid   (pix1_valid),
    .pix1_beat    (pix1_beat),
    .pix1_ready   (pix1_ready),
    .pix2_valid   (pix2_valid),
    .pix2_beat    (pix2_beat),
    .pix2_ready   (pix2_ready),
    .out_valid    (out_valid),
    .out_data     (out_data),
    .out_ready    (out_ready)
  );

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  // sampled mid-cycle, the transfer itself is on the next rising edge
  always @(negedge aclk) begin
    if (!reset && out_valid && out_ready) begin
      got_q.push_back(out_data);
    end
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at the first error");
  endtask

  `include "tb_conv_pool_checks.svh"

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  function automatic logic [15:0] random_bits(input int n);
    logic [15:0] r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[14:0], lfsr_state[0]};  // newest bit at the bottom
    end
    return r;
  endfunction

  function automatic window_t make_window(input int vals [TAPS]);
    window_t w;
    for (int i = 0; i < TAPS; i++) begin
      w[i] = word_t'(vals[i]);
    end
    return w;
  endfunction

  function automatic window_t flat_window(input int v);
    window_t w;
    for (int i = 0; i < TAPS; i++) begin
      w[i] = word_t'(v);
    end
    return w;
  endfunction

  function automatic window_t random_window();
    window_t     w;
    logic [15:0] bits;
    for (int i = 0; i < TAPS; i++) begin
      bits = random_bits(8);
      w[i] = bits[7:0];
    end
    return w;
  endfunction

  task automatic drive_port(input int port, input logic valid, input stream_beat_t beat);
    case (port)
      0: begin
        weight_valid <= valid;
        weight_beat  <= beat;
      end
      1: begin
        pix1_valid <= valid;
        pix1_beat  <= beat;
      end
      default: begin
        pix2_valid <= valid;
        pix2_beat  <= beat;
      end
    endcase
  endtask

  task automatic send_beats(input int port, input window_t words);
    stream_beat_t beat;
    for (int i = 0; i < TAPS; i++) begin
      @(posedge aclk);
      beat.data = words[i];
      beat.last = (i == TAPS - 1);
      drive_port(port, 1'b1, beat);
      wait_ready(port);
    end
    @(posedge aclk);  // final beat moves here
    drive_port(port, 1'b0, '0);
  endtask

  task automatic load_kernel(input kernel_t k);
    send_beats(0, k);
    kernel_now = k;
  endtask

  // one window per lane side by side, one result expected
  task automatic run_pair(input window_t w1, input window_t w2, input string what);
    got_q.delete();
    fork
      send_beats(1, w1);
      send_beats(2, w2);
    join
    wait_outputs(1);
    check_out(got_q[0], pooled_out(w1, w2, kernel_now), what);
  endtask

  task automatic test_basic();
    int      vals [TAPS];
    window_t w1;
    window_t w2;
    vals = '{1, 2, 3, -1, 4, -2, 1, 0, 2};
    load_kernel(make_window(vals));
    w1 = flat_window(10);
    vals = '{20, 0, 10, 0, 20, 0, 5, 0, 10};
    w2 = make_window(vals);
    check_sum(dot_product(w1, kernel_now), acc_t'(100), "basic lane 1 sum");
    check_sum(dot_product(w2, kernel_now), acc_t'(155), "basic lane 2 sum");
    check_out(pooled_out(w1, w2, kernel_now), word_t'(9), "basic model output");
    run_pair(w1, w2, "basic output");
  endtask

  task automatic test_negative();
    window_t w1;
    window_t w2;
    w1 = flat_window(-100);
    w2 = flat_window(-50);
    check_sum(dot_product(w1, kernel_now), acc_t'(-1000), "negative lane 1 sum");
    check_sum(dot_product(w2, kernel_now), acc_t'(-500), "negative lane 2 sum");
    check_sum(leaky_relu(acc_t'(-500)), acc_t'(-63), "leaky slope of -500");
    check_out(pooled_out(w1, w2, kernel_now), word_t'(-4), "negative model output");
    run_pair(w1, w2, "negative output");
  endtask

  task automatic test_saturate();
    load_kernel(flat_window(100));
    check_sum(dot_product(flat_window(100), kernel_now), acc_t'(90000), "large positive sum");
    check_sum(leaky_relu(acc_t'(-90000)), acc_t'(-11250), "leaky slope of -90000");
    check_out(requantize(acc_t'(90000)), word_t'(127), "model upper clamp");
    run_pair(flat_window(100), flat_window(0), "upper saturated output");
    run_pair(flat_window(-100), flat_window(-100), "lower saturated output");
    check_out(got_q[0], word_t'(-128), "lower clamp value");
  endtask

  task automatic test_backpressure();
    window_t w1 [3];
    window_t w2 [3];
    word_t   held;
    for (int i = 0; i < 3; i++) begin
      w1[i] = random_window();
      w2[i] = random_window();
    end
    got_q.delete();
    @(posedge aclk);
    out_ready <= 1'b0;
    fork
      for (int i = 0; i < 3; i++) send_beats(1, w1[i]);
      for (int i = 0; i < 3; i++) send_beats(2, w2[i]);
      begin
        wait_out_valid();
        held = out_data;
        repeat (STALL_CYCLES) begin
          @(negedge aclk);
          if (!out_valid) begin
            abort_run("out_valid dropped while out_ready was held low");
          end
          check_out(out_data, held, "stalled out_data");
        end
        @(posedge aclk);
        out_ready <= 1'b1;
      end
    join
    wait_outputs(3);
    for (int i = 0; i < 3; i++) begin
      check_out(got_q[i], pooled_out(w1[i], w2[i], kernel_now), "backpressure output");
    end
  endtask

  task automatic test_stagger();
    window_t     w1;
    window_t     w2;
    logic [15:0] gap;
    w1 = random_window();
    w2 = random_window();
    gap = random_bits(4);
    got_q.delete();
    send_beats(1, w1);
    repeat (int'(gap) + 2) begin
      @(negedge aclk);
      if (out_valid) begin
        abort_run("out_valid rose before lane 2 sent its window");
      end
    end
    send_beats(2, w2);
    if (got_q.size() != 0) begin
      abort_run("a result came out before lane 2 finished its window");
    end
    wait_outputs(1);
    check_out(got_q[0], pooled_out(w1, w2, kernel_now), "staggered output");
  endtask

  task automatic test_reload();
    int      vals [TAPS];
    window_t w1;
    window_t w2;
    vals = '{-3, 5, 0, 2, -1, 4, 7, -2, 1};
    load_kernel(make_window(vals));
    w1 = flat_window(10);
    vals = '{20, 0, 10, 0, 20, 0, 5, 0, 10};
    w2 = make_window(vals);
    check_sum(dot_product(w1, kernel_now), acc_t'(130), "reload lane 1 sum");
    check_sum(dot_product(w2, kernel_now), acc_t'(-35), "reload lane 2 sum");
    check_out(pooled_out(w1, w2, kernel_now), word_t'(8), "reload model output");
    run_pair(w1, w2, "reload output");
    run_pair(random_window(), random_window(), "reload random output");
  endtask

  initial begin
    reset        = 1'b1;
    weight_valid = 1'b0;
    weight_beat  = '0;
    pix1_valid   = 1'b0;
    pix1_beat    = '0;
    pix2_valid   = 1'b0;
    pix2_beat    = '0;
    out_ready    = 1'b1;
    lfsr_state   = LFSR_SEED;
    kernel_now   = '0;
    repeat (3) @(posedge aclk);
    reset <= 1'b0;

    test_basic();
    test_negative();
    test_backpressure();
    test_stagger();
    test_saturate();  // swaps in a large kernel
    test_reload();

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire
